// ==== sources.f ====
source/cpuPkg.sv
source/dataBusIf.sv
source/progMem.sv
source/regFile.sv
source/decoder.sv
source/alu.sv
source/dataMem.sv
source/singleCpu.sv
test/clockGen.sv
test/singleCpu_chk.sv
test/singleCpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the singleCpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module singleCpu_tb --Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// ==== test/singleCpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module singleCpu_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_ROWS     = 21;
    localparam int WATCH_CYCLES = RESET_CYCLES + 2 * NUM_ROWS + 20;
    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;

    logic CLK, rstN, progWe, wbValid;
    logic [5:0]  progAddr;
    logic [4:0]  wbReg;
    logic [31:0] progData, pc, inst, wbData;

    // Program table, one row per instruction word
    logic [31:0] instTab [NUM_ROWS];
    logic        expValid [NUM_ROWS];
    logic [4:0]  expReg [NUM_ROWS];
    logic [31:0] expData [NUM_ROWS];
    logic [31:0] expNext [NUM_ROWS];

    integer      seed = 32'h9d55227b;
    int          errorCount = 0;
    int          testCount = 0;
    logic [31:0] aVal, bVal, cVal;

    clockGen clkGen (.CLK(CLK));

    singleCpu uut (
        .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .inst(inst), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] swWord(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beqWord(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic setRow(input int idx, input logic [31:0] word, input logic valid,
                          input logic [4:0] dest, input logic [31:0] data,
                          input logic [31:0] next);
        instTab[idx]  = word;
        expValid[idx] = valid;
        expReg[idx]   = dest;
        expData[idx]  = data;
        expNext[idx]  = next;
    endtask

    task automatic compareSignal(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic buildProgram();
        logic [31:0] randA, randB;
        randA = $random(seed);
        randB = $random(seed);
        aVal = {22'b0, randA[9:0]} + 32'd1;        // Positive, never equal to cVal
        bVal = {{20{randB[11]}}, randB[11:0]};     // Any 12-bit signed value
        cVal = 32'hffff_fffb;                      // -5
        setRow(0, iType(aVal[11:0], 5'd0, 3'b000, 5'd1, OPC_IMM), 1'b1, 5'd1, aVal, 32'd4);
        setRow(1, iType(bVal[11:0], 5'd0, 3'b000, 5'd2, OPC_IMM), 1'b1, 5'd2, bVal, 32'd8);
        setRow(2, iType(12'hffb, 5'd0, 3'b000, 5'd3, OPC_IMM), 1'b1, 5'd3, cVal, 32'd12);
        setRow(3, rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, aVal + bVal, 32'd16);
        setRow(4, rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, aVal - bVal, 32'd20);
        setRow(5, rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 1'b1, 5'd6, aVal & bVal, 32'd24);
        setRow(6, rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 1'b1, 5'd7, aVal | bVal, 32'd28);
        setRow(7, rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 1'b1, 5'd8, aVal ^ bVal, 32'd32);
        // x3 holds -5 and x1 is positive
        setRow(8, rType(7'h00, 5'd1, 5'd3, 3'b010, 5'd9), 1'b1, 5'd9, 32'd1, 32'd36);
        setRow(9, rType(7'h00, 5'd3, 5'd1, 3'b010, 5'd10), 1'b1, 5'd10, 32'd0, 32'd40);
        setRow(10, rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd11), 1'b1, 5'd11, cVal - aVal, 32'd44);
        setRow(11, iType(12'd7, 5'd1, 3'b000, 5'd0, OPC_IMM), 1'b0, 5'd0, '0, 32'd48);
        setRow(12, rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd12), 1'b1, 5'd12, aVal, 32'd52);
        setRow(13, swWord(12'd8, 5'd4, 5'd0), 1'b0, 5'd0, '0, 32'd56);
        setRow(14, iType(12'd8, 5'd0, 3'b010, 5'd13, OPC_LOAD), 1'b1, 5'd13,
               aVal + bVal, 32'd60);
        setRow(15, beqWord(13'd8, 5'd4, 5'd13), 1'b0, 5'd0, '0, 32'd68);  // Taken
        setRow(16, iType(12'd99, 5'd0, 3'b000, 5'd14, OPC_IMM), 1'b1, 5'd14, 32'd99, 32'd68);
        setRow(17, beqWord(13'd8, 5'd3, 5'd1), 1'b0, 5'd0, '0, 32'd72);   // Not taken
        setRow(18, iType(12'd1, 5'd12, 3'b000, 5'd15, OPC_IMM), 1'b1, 5'd15,
               aVal + 32'd1, 32'd76);
        setRow(19, rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd16), 1'b1, 5'd16, 32'd0, 32'd80);
        setRow(20, beqWord(13'd0, 5'd0, 5'd0), 1'b0, 5'd0, '0, 32'd80);   // Spin in place
    endtask

    // Watchdog
    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not reach its last row in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int idx;
        int rowErrors;
        logic [31:0] expPc;
        logic running;
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        buildProgram();
        repeat (RESET_CYCLES) @(posedge CLK);
        for (int i = 0; i < NUM_ROWS; i++) begin  // Reset stays low while loading
            @(posedge CLK);
            progWe   <= 1'b1;
            progAddr <= 6'(i);
            progData <= instTab[i];
        end
        @(posedge CLK);
        progWe <= 1'b0;
        @(negedge CLK);
        rowErrors = errorCount;
        compareSignal("pc", pc, 32'd0);
        compareSignal("wbValid", {31'b0, wbValid}, 32'd0);
        compareSignal("inst", inst, instTab[0]);
        $display("test reset: %s", (errorCount == rowErrors) ? "ok" : "failed");
        @(posedge CLK);
        rstN <= 1'b1;
        expPc = '0;
        running = 1'b1;
        while (running) begin
            @(negedge CLK);
            rowErrors = errorCount;
            compareSignal("pc", pc, expPc);
            idx = int'(expPc >> 2);
            compareSignal("inst", inst, instTab[idx]);
            compareSignal("wbValid", {31'b0, wbValid}, {31'b0, expValid[idx]});
            if (expValid[idx]) begin
                compareSignal("wbReg", {27'b0, wbReg}, {27'b0, expReg[idx]});
                compareSignal("wbData", wbData, expData[idx]);
            end
            testCount++;
            $display("test %0d row %0d pc %h: %s", testCount, idx, expPc,
                     (errorCount == rowErrors) ? "ok" : "failed");
            expPc = expNext[idx];
            running = (idx != NUM_ROWS - 1);
        end
        @(negedge CLK);
        compareSignal("pc", pc, expPc);   // Final row branches onto itself
        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/singleCpu_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module singleCpu_chk import cpuPkg::*; (
    input wire logic        CLK,
    input wire logic        rstN,
    input wire logic [31:0] pc,
    input wire logic [31:0] inst,
    input wire logic        wbValid,
    input wire logic [4:0]  wbReg
);

    // x0 is never reported as a destination
    noZeroWrite: assert property (@(posedge CLK) wbValid |-> wbReg != 5'd0)
        else $error("retire trace shows a write to x0");

    resetQuiet: assert property (@(posedge CLK) !rstN |-> !wbValid)
        else $error("wbValid high while reset is asserted");

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // Stores and branches never write a register
    noWriteOnStoreBranch: assert property (@(posedge CLK) disable iff (!rstN)
        (inst[6:0] == OP_STORE || inst[6:0] == OP_BRANCH) |-> !wbValid)
        else $error("store or branch reported a register write");

endmodule

bind singleCpu singleCpu_chk chk (.*);

`default_nettype wire

// ==== test/clockGen.sv ====
`default_nettype none
`timescale 1ns/1ps

module clockGen (
    output logic CLK
);

    initial CLK = 1'b0;

    always #5 CLK = ~CLK; // 10 ns period

endmodule

`default_nettype wire

// ==== source/singleCpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module singleCpu import cpuPkg::*; (
    input  wire logic      CLK,
    input  wire logic      rstN,
    input  wire logic      progWe,
    input  wire progAddr_t progAddr,
    input  wire word_t     progData,
    output      word_t     pc,
    output      word_t     inst,
    output      logic      wbValid,
    output      regAddr_t  wbReg,
    output      word_t     wbData
);

    regAddr_t rs1, rs2, rd;
    word_t    imm;
    aluOp_t   aluOp;
    logic     aluSrcImm, regWrite, memWrite, memToReg, branch;
    word_t    rd1, rd2;
    word_t    aluB, aluResult;
    logic     aluZero;
    word_t    nextPc;

    dataBusIf dataBus ();

    progMem uProgMem (
        .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .fetchAddr(pc[PROG_DEPTH_LOG2+1:2]), .fetchData(inst)
    );

    decoder uDecoder (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .regWrite(regWrite), .memWrite(memWrite),
        .memToReg(memToReg), .branch(branch)
    );

    regFile uRegFile (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(wbValid), .wd(wbData), .rd1(rd1), .rd2(rd2)
    );

    assign aluB = aluSrcImm ? imm : rd2; // Immediate for addi, lw, sw

    alu uAlu (.a(rd1), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero));

    // Core side of the data bus, no stores while loading
    assign dataBus.addr  = aluResult;
    assign dataBus.wdata = rd2;
    assign dataBus.we    = memWrite && rstN;

    dataMem uDataMem (.CLK(CLK), .bus(dataBus.memory));

    // Taken beq jumps relative to its own pc
    assign nextPc = (branch && aluZero) ? pc + imm : pc + 32'd4;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Retire trace
    assign wbValid = regWrite && rstN; // Held low during program load
    assign wbReg   = rd;
    assign wbData  = memToReg ? dataBus.rdata : aluResult;

endmodule

`default_nettype wire

// ==== source/dataMem.sv ====
`default_nettype none
`timescale 1ns/1ps

module dataMem import cpuPkg::*; (
    input wire logic CLK,
    dataBusIf.memory bus
);

    logic [DATA_DEPTH_LOG2-1:0] wordIdx;

    word_t mem [2**DATA_DEPTH_LOG2];

    // Word addressed, byte offset bits ignored
    assign wordIdx = bus.addr[DATA_DEPTH_LOG2+1:2];

    always_ff @(posedge CLK) begin
        if (bus.we) begin
            mem[wordIdx] <= bus.wdata;
        end
    end

    assign bus.rdata = mem[wordIdx];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  wire word_t  a,
    input  wire word_t  b,
    input  wire aluOp_t op,
    output      word_t  result,
    output      logic   zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)}; // Signed compare
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // beq equality

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
    input  wire word_t    inst,
    output      regAddr_t rs1,
    output      regAddr_t rs2,
    output      regAddr_t rd,
    output      word_t    imm,
    output      aluOp_t   aluOp,
    output      logic     aluSrcImm,
    output      logic     regWrite,
    output      logic     memWrite,
    output      logic     memToReg,
    output      logic     branch
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       writesRd; // Instruction class writes a register

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // x0 destination never counts as a write
    assign regWrite = writesRd && (rd != '0);

    always_comb begin
        imm       = {{20{inst[31]}}, inst[31:20]}; // I-type by default
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        writesRd  = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        case (opcode)
            OP_RTYPE, OP_ITYPE: begin
                writesRd  = 1'b1;
                aluSrcImm = (opcode == OP_ITYPE);
                case (funct3)
                    F3_ADDSUB: aluOp = (opcode == OP_RTYPE && inst[30]) ? ALU_SUB : ALU_ADD;
                    F3_SLT:    aluOp = ALU_SLT;
                    F3_XOR:    aluOp = ALU_XOR;
                    F3_OR:     aluOp = ALU_OR;
                    F3_AND:    aluOp = ALU_AND;
                    default:   writesRd = 1'b0; // Shifts are not supported
                endcase
            end
            OP_LOAD: begin
                aluSrcImm = 1'b1;
                writesRd  = (funct3 == F3_WORD);
                memToReg  = 1'b1;
            end
            OP_STORE: begin
                imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                aluSrcImm = 1'b1;
                memWrite  = (funct3 == F3_WORD);
            end
            OP_BRANCH: begin
                // Equality is tested through the ALU zero flag
                imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                aluOp  = ALU_SUB;
                branch = (funct3 == F3_BEQ);
            end
            default: ; // Unsupported opcodes act as a no-op
        endcase
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  wire logic     CLK,
    input  wire logic     rstN,
    input  wire regAddr_t rs1,
    input  wire regAddr_t rs2,
    input  wire regAddr_t rd,
    input  wire logic     we,
    input  wire word_t    wd,
    output      word_t    rd1,
    output      word_t    rd2
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads as zero whatever is stored
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== source/progMem.sv ====
`default_nettype none
`timescale 1ns/1ps

module progMem import cpuPkg::*; (
    input  wire logic      CLK,
    input  wire logic      rstN,
    input  wire logic      progWe,
    input  wire progAddr_t progAddr,
    input  wire word_t     progData,
    input  wire progAddr_t fetchAddr,
    output      word_t     fetchData
);

    word_t mem [2**PROG_DEPTH_LOG2];

    // Loading is only allowed while the core is held in reset
    always_ff @(posedge CLK) begin
        if (!rstN && progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign fetchData = mem[fetchAddr]; // Combinational fetch

endmodule

`default_nettype wire

// ==== source/dataBusIf.sv ====
`default_nettype none
`timescale 1ns/1ps

// Single-cycle data access, rdata follows addr in the same cycle
interface dataBusIf import cpuPkg::*; ();

    word_t addr;  // Byte address
    word_t wdata;
    logic  we;    // Store on the rising edge
    word_t rdata;

    modport core (output addr, output wdata, output we, input rdata);
    modport memory (input addr, input wdata, input we, output rdata);

endinterface

`default_nettype wire

// ==== source/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Memory sizes in words
    localparam int PROG_DEPTH_LOG2 = 6;
    localparam int DATA_DEPTH_LOG2 = 6;

    typedef logic [31:0]                word_t;     // Data or instruction word
    typedef logic [4:0]                 regAddr_t;  // x0 .. x31
    typedef logic [PROG_DEPTH_LOG2-1:0] progAddr_t; // Instruction word index

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 codes for arithmetic and logic
    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;

    // funct3 codes for memory and branch
    localparam logic [2:0] F3_WORD   = 3'b010; // lw / sw
    localparam logic [2:0] F3_BEQ    = 3'b000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

endpackage

`default_nettype wire
